// File: design/cpu_params.svh
// Core widths and encodings
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_W     16   // Data word and PC width
`define REG_CNT    8    // r0 to r7
`define DMEM_DEPTH 256  // Data memory words

// Opcodes, bits 15:11 of every format
`define OP_HALT  5'b00000
`define OP_NOP   5'b00001
`define OP_J     5'b00100
`define OP_JAL   5'b00110
`define OP_ADDI  5'b01000
`define OP_SUBI  5'b01001
`define OP_BEQZ  5'b01100
`define OP_BNEZ  5'b01101
`define OP_ST    5'b10000
`define OP_LD    5'b10001
`define OP_LBI   5'b11000
`define OP_RTYPE 5'b11011

// R-format function field
`define FN_ADD  2'b00
`define FN_SUB  2'b01
`define FN_XOR  2'b10
`define FN_ANDN 2'b11

`endif

// File: design/cpuPkg.sv
// Instruction word type
package cpuPkg;

  // One 16-bit word, four ways to slice it
  typedef union packed {
    struct packed {
      logic [4:0] op;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] funct;  // ALU function
    } rFmt;
    struct packed {
      logic [4:0] op;
      logic [2:0] rs;
      logic [2:0] rd;     // Dest, or store data source
      logic [4:0] imm5;
    } iFmt;
    struct packed {
      logic [4:0] op;
      logic [2:0] rs;     // Tested reg, or LBI dest
      logic [7:0] imm8;
    } bFmt;
    struct packed {
      logic [4:0]  op;
      logic [10:0] imm11; // Jump displacement
    } jFmt;
  } instrWord;

endpackage

// File: design/pipeBuses.sv
// Pipeline latch buses
`include "cpu_params.svh"

// ID/EX contents
interface idExBus;
  logic               valid;
  logic [`DATA_W-1:0] pc, a, b, imm;
  logic [2:0]         dest;
  logic               regWrite, memRead, memWrite;
  logic [2:0]         aluFn;          // Bit 2 picks imm as second operand
  logic               isBranchZero, branchOnZero;
  logic               isJump, link;   // Link writes pc+1
  logic               halt, illegal;

  modport producer (
    output valid, pc, a, b, imm, dest, regWrite, memRead, memWrite, aluFn,
           isBranchZero, branchOnZero, isJump, link, halt, illegal
  );
  modport consumer (
    input valid, pc, a, b, imm, dest, regWrite, memRead, memWrite, aluFn,
          isBranchZero, branchOnZero, isJump, link, halt, illegal
  );
  modport monitor (input valid, dest, regWrite);  // Hazard view
endinterface

// EX/MEM contents
interface exMemBus;
  logic               valid;
  logic [`DATA_W-1:0] pc, result;     // Result doubles as memory address
  logic [`DATA_W-1:0] storeData;
  logic [2:0]         dest;
  logic               regWrite, memRead, memWrite;
  logic               halt, illegal;

  modport producer (
    output valid, pc, result, storeData, dest, regWrite, memRead, memWrite, halt, illegal
  );
  modport consumer (
    input valid, pc, result, storeData, dest, regWrite, memRead, memWrite, halt, illegal
  );
  modport monitor (input valid, dest, regWrite);
endinterface

// MEM/WB contents, also the retire view
interface memWbBus;
  logic               valid;
  logic [`DATA_W-1:0] pc;
  logic [`DATA_W-1:0] wbData;
  logic [2:0]         dest;
  logic               regWrite;
  logic               halt, illegal;

  modport producer (
    output valid, pc, wbData, dest, regWrite, halt, illegal
  );
  modport consumer (
    input valid, pc, wbData, dest, regWrite, halt, illegal
  );
endinterface

// File: design/fetchStage.sv
// Instruction fetch
`include "cpu_params.svh"

module fetchStage (
  input  logic               clk,
  input  logic               arstN,
  input  logic               stall,     // Hold from hazard unit
  input  logic               redirect,  // Taken branch or jump in EX
  input  logic               halted,
  input  logic [`DATA_W-1:0] target,
  input  cpuPkg::instrWord   imemData,
  output logic [`DATA_W-1:0] imemAddr,
  output cpuPkg::instrWord   instr,
  output logic [`DATA_W-1:0] pc,
  output logic               valid
);

  logic [`DATA_W-1:0] pcReg;  // Word address being fetched
  logic               advance;

  // New word enters IF/ID only on a clean cycle
  assign advance  = !halted && !redirect && !stall;
  assign imemAddr = pcReg;

  // PC and IF/ID valid
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcReg <= '0;
      valid <= 1'b0;
    end else if (halted) begin
      valid <= 1'b0;            // Frozen for good
    end else if (redirect) begin
      pcReg <= target;
      valid <= 1'b0;            // Wrong-path word dropped
    end else if (!stall) begin
      pcReg <= pcReg + 1'b1;    // Word-addressed PC
      valid <= 1'b1;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (advance) begin
      instr <= imemData;
      pc    <= pcReg;
    end
  end

  // Stall keeps pcReg and the latch as they are,
  // so the same word is decoded again next cycle

endmodule

// File: design/regFile.sv
// Register file with write-through
`include "cpu_params.svh"

module regFile (
  input  logic               clk,
  input  logic               arstN,
  input  logic [2:0]         rdAddrA,
  input  logic [2:0]         rdAddrB,
  output logic [`DATA_W-1:0] rdDataA,
  output logic [`DATA_W-1:0] rdDataB,
  input  logic               wrEn,
  input  logic [2:0]         wrAddr,
  input  logic [`DATA_W-1:0] wrData
);

  logic [`DATA_W-1:0] regs [`REG_CNT];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Bypass the writeback value into a same-cycle read
  assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

  // r0 is not hardwired, it behaves like r1..r7

endmodule

// File: design/decodeStage.sv
// Instruction decode and ID/EX latch
`include "cpu_params.svh"

module decodeStage (
  input  logic               clk,
  input  logic               arstN,
  input  cpuPkg::instrWord   instr,
  input  logic [`DATA_W-1:0] pc,
  input  logic               valid,
  input  logic               stall,
  input  logic               redirect,
  memWbBus.consumer          wb,
  output logic [2:0]         srcA,
  output logic [2:0]         srcB,
  output logic               useA,
  output logic               useB,
  idExBus.producer           idEx
);

  logic [`DATA_W-1:0] rdDataA, rdDataB;
  logic [`DATA_W-1:0] imm, imm5, imm8, imm11;
  logic [2:0]         dest;
  logic [2:0]         aluFn;
  logic               needA, needB;
  logic               regWrite, memRead, memWrite;
  logic               isBranchZero, branchOnZero, isJump, link;
  logic               halt, illegal;
  logic               bubble;

  regFile regFile_i (
    .clk     (clk),
    .arstN   (arstN),
    .rdAddrA (srcA),
    .rdAddrB (srcB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (wb.regWrite),  // Already cleared for killed or bubble slots
    .wrAddr  (wb.dest),
    .wrData  (wb.wbData)
  );

  // Sign-extended immediates
  assign imm5  = {{(`DATA_W-5){instr.iFmt.imm5[4]}}, instr.iFmt.imm5};
  assign imm8  = {{(`DATA_W-8){instr.bFmt.imm8[7]}}, instr.bFmt.imm8};
  assign imm11 = {{(`DATA_W-11){instr.jFmt.imm11[10]}}, instr.jFmt.imm11};

  always_comb begin
    srcA = instr.rFmt.rs;      // Same bits in every format
    srcB = instr.rFmt.rt;
    dest = instr.rFmt.rd;
    imm  = imm5;
    aluFn = {1'b0, `FN_ADD};
    {needA, needB, regWrite, memRead, memWrite} = '0;
    {isBranchZero, branchOnZero, isJump, link, halt, illegal} = '0;
    case (instr.rFmt.op)
      `OP_HALT:  halt = 1'b1;
      `OP_NOP:   ;
      `OP_RTYPE: begin
        {needA, needB, regWrite} = 3'b111;
        aluFn = {1'b0, instr.rFmt.funct};
      end
      `OP_ADDI, `OP_SUBI, `OP_LD: begin
        {needA, regWrite} = 2'b11;
        dest    = instr.iFmt.rd;
        memRead = (instr.iFmt.op == `OP_LD);
        aluFn   = {1'b1, (instr.iFmt.op == `OP_SUBI) ? `FN_SUB : `FN_ADD};
      end
      `OP_ST: begin
        {needA, needB, memWrite} = 3'b111;
        srcB  = instr.iFmt.rd;   // Store data register
        aluFn = {1'b1, `FN_ADD}; // Address rs + imm
      end
      `OP_LBI: begin
        regWrite = 1'b1;
        dest  = instr.bFmt.rs;
        imm   = imm8;
        aluFn = {1'b1, `FN_ADD}; // Zero plus imm
      end
      `OP_BEQZ, `OP_BNEZ: begin
        {needA, isBranchZero} = 2'b11;
        branchOnZero = (instr.bFmt.op == `OP_BEQZ);
        imm = imm8;
      end
      `OP_J, `OP_JAL: begin
        isJump   = 1'b1;
        imm      = imm11;
        link     = (instr.jFmt.op == `OP_JAL);
        regWrite = link;
        dest     = 3'd7;             // Link register
      end
      default: illegal = 1'b1;
    endcase
  end

  assign useA   = valid & needA;
  assign useB   = valid & needB;
  assign bubble = stall | redirect | !valid;

  // ID/EX control, zeroed for a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {idEx.valid, idEx.regWrite, idEx.memRead, idEx.memWrite} <= '0;
      {idEx.isBranchZero, idEx.isJump, idEx.link, idEx.halt, idEx.illegal} <= '0;
    end else if (bubble) begin
      {idEx.valid, idEx.regWrite, idEx.memRead, idEx.memWrite} <= '0;
      {idEx.isBranchZero, idEx.isJump, idEx.link, idEx.halt, idEx.illegal} <= '0;
    end else begin
      {idEx.valid, idEx.regWrite, idEx.memRead, idEx.memWrite} <=
        {1'b1, regWrite, memRead, memWrite};
      {idEx.isBranchZero, idEx.isJump, idEx.link, idEx.halt, idEx.illegal} <=
        {isBranchZero, isJump, link, halt, illegal};
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    idEx.pc           <= pc;
    idEx.a            <= needA ? rdDataA : '0;  // LBI sees a zero operand
    idEx.b            <= rdDataB;
    idEx.imm          <= imm;
    idEx.dest         <= dest;
    idEx.aluFn        <= aluFn;
    idEx.branchOnZero <= branchOnZero;
  end

endmodule

// File: design/hazardUnit.sv
// Read-after-write stall detection

module hazardUnit (
  input  logic [2:0]  srcA,
  input  logic [2:0]  srcB,
  input  logic        useA,   // Already qualified by IF/ID valid
  input  logic        useB,
  idExBus.monitor     idEx,
  exMemBus.monitor    exMem,
  output logic        stall
);

  logic hitA, hitB;

  // True when an older, still-unwritten result targets regIdx
  function automatic logic pending(input logic [2:0] regIdx);
    logic exHit;
    logic memHit;
    exHit  = idEx.valid && idEx.regWrite && idEx.dest == regIdx;
    memHit = exMem.valid && exMem.regWrite && exMem.dest == regIdx;
    return exHit || memHit;
  endfunction

  // MEM/WB needs no check since writeback passes through the regfile
  always_comb begin
    hitA = useA && pending(srcA);
    hitB = useB && pending(srcB);
  end

  // Held until the producer reaches writeback
  assign stall = hitA || hitB;

  // No forwarding paths exist, so a dependent pair costs
  // up to two bubbles between them

endmodule

// File: design/executeStage.sv
// ALU, branch resolution and EX/MEM latch
`include "cpu_params.svh"

module executeStage (
  input  logic               clk,
  input  logic               arstN,
  idExBus.consumer           idEx,
  exMemBus.producer          exMem,
  output logic               redirect,
  output logic [`DATA_W-1:0] target
);

  logic [`DATA_W-1:0] opB;      // Register b or immediate
  logic [`DATA_W-1:0] aluOut;
  logic [`DATA_W-1:0] pcPlus1;
  logic [`DATA_W-1:0] result;
  logic               aZero;
  logic               taken;

  assign opB = idEx.aluFn[2] ? idEx.imm : idEx.b;

  always_comb begin
    case (idEx.aluFn[1:0])
      `FN_ADD:  aluOut = idEx.a + opB;   // Also LBI with a forced to zero
      `FN_SUB:  aluOut = opB - idEx.a;   // Reverse subtract
      `FN_XOR:  aluOut = idEx.a ^ opB;
      `FN_ANDN: aluOut = idEx.a & ~opB;
      default:  aluOut = idEx.a + opB;
    endcase
  end

  assign pcPlus1 = idEx.pc + 1'b1;
  assign target  = pcPlus1 + idEx.imm;   // PC-relative for all redirects

  // Branch condition on register a
  assign aZero = (idEx.a == '0);
  assign taken = idEx.isJump || (idEx.isBranchZero && (aZero == idEx.branchOnZero));

  // Bubbles carry no branch or jump bits
  assign redirect = idEx.valid && taken;

  // JAL writes the return address
  assign result = idEx.link ? pcPlus1 : aluOut;

  // EX/MEM control
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem.valid    <= 1'b0;
      exMem.regWrite <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.halt     <= 1'b0;
      exMem.illegal  <= 1'b0;
    end else begin
      exMem.valid    <= idEx.valid;
      exMem.regWrite <= idEx.regWrite;
      exMem.memRead  <= idEx.memRead;
      exMem.memWrite <= idEx.memWrite;
      exMem.halt     <= idEx.halt;
      exMem.illegal  <= idEx.illegal;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    exMem.pc        <= idEx.pc;
    exMem.result    <= result;
    exMem.storeData <= idEx.b;   // ST source from iFmt rd
    exMem.dest      <= idEx.dest;
  end

  // Redirect lands on the next edge; fetch and decode
  // turn their two younger slots into bubbles at that edge

endmodule

// File: design/memoryStage.sv
// Data memory and MEM/WB latch
`include "cpu_params.svh"

module memoryStage (
  input  logic      clk,
  input  logic      arstN,
  exMemBus.consumer exMem,
  memWbBus.producer wb,
  output logic      halted,
  output logic      err
);

  localparam int addrW = $clog2(`DMEM_DEPTH);

  logic [`DATA_W-1:0] dmem [`DMEM_DEPTH];
  logic [addrW-1:0]   addr;      // Low bits of the ALU result
  logic [`DATA_W-1:0] loadData;
  logic               stopping;  // HALT or illegal retiring, or already halted

  assign addr     = exMem.result[addrW-1:0];
  assign loadData = dmem[addr];   // Asynchronous read
  assign stopping = halted || (wb.valid && (wb.halt || wb.illegal));

  // Younger stores die with the halt
  always_ff @(posedge clk) begin
    if (exMem.memWrite && !stopping) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  // MEM/WB control and sticky flags
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {wb.valid, wb.regWrite, wb.halt, wb.illegal} <= '0;
      halted <= 1'b0;
      err    <= 1'b0;
    end else begin
      wb.valid    <= exMem.valid && !stopping;
      wb.regWrite <= exMem.regWrite && !stopping;
      wb.halt     <= exMem.halt && !stopping;
      wb.illegal  <= exMem.illegal && !stopping;
      if (stopping) halted <= 1'b1;
      if (wb.valid && wb.illegal) err <= 1'b1;  // Bad opcode retired
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    wb.pc     <= exMem.pc;
    wb.wbData <= exMem.memRead ? loadData : exMem.result;
    wb.dest   <= exMem.dest;
  end

endmodule

// File: design/cpuCore.sv
// Five-stage pipeline top
`include "cpu_params.svh"

module cpuCore (
  input  logic               clk,
  input  logic               arstN,
  output logic [`DATA_W-1:0] imemAddr,
  input  cpuPkg::instrWord   imemData,
  output logic               retireValid,
  output logic [`DATA_W-1:0] retirePc,
  output logic               retireWrite,
  output logic [2:0]         retireReg,
  output logic [`DATA_W-1:0] retireData,
  output logic               halted,
  output logic               err
);
  import cpuPkg::*;

  instrWord           ifInstr;   // IF/ID word
  logic [`DATA_W-1:0] ifPc;
  logic               ifValid;
  logic               stall;
  logic               redirect;
  logic [`DATA_W-1:0] target;
  logic [2:0]         srcA, srcB;
  logic               useA, useB;

  idExBus  idEx ();
  exMemBus exMem ();
  memWbBus memWb ();

  fetchStage fetchStage_i (
    .clk, .arstN, .stall, .redirect, .halted, .target,
    .imemData, .imemAddr,
    .instr (ifInstr),
    .pc    (ifPc),
    .valid (ifValid)
  );

  decodeStage decodeStage_i (
    .clk, .arstN,
    .instr (ifInstr),
    .pc    (ifPc),
    .valid (ifValid),
    .stall, .redirect,
    .wb    (memWb),
    .srcA, .srcB, .useA, .useB,
    .idEx  (idEx)
  );

  hazardUnit hazardUnit_i (.srcA, .srcB, .useA, .useB, .idEx(idEx), .exMem(exMem), .stall);

  executeStage executeStage_i (.clk, .arstN, .idEx(idEx), .exMem(exMem), .redirect, .target);

  memoryStage memoryStage_i (.clk, .arstN, .exMem(exMem), .wb(memWb), .halted, .err);

  // Retire view straight off MEM/WB
  assign retireValid = memWb.valid;
  assign retirePc    = memWb.pc;
  assign retireWrite = memWb.regWrite;
  assign retireReg   = memWb.dest;
  assign retireData  = memWb.wbData;

endmodule

// File: testbench/tbCpu.sv
// Pipelined CPU testbench
`include "cpu_params.svh"

module tbCpu;
  import cpuPkg::*;

  logic               clk;
  logic               arstN;
  logic [`DATA_W-1:0] imemAddr;
  instrWord           imemData;
  logic               retireValid, retireWrite, halted, err;
  logic [`DATA_W-1:0] retirePc, retireData;
  logic [2:0]         retireReg;

  instrWord           prog [256];          // Instruction memory image
  int                 progLen;
  logic [2:0]         lastDest;            // Feeds back-to-back dependencies
  logic [31:0]        lcgState = 32'h5de0;
  logic [`DATA_W-1:0] modelRegs [`REG_CNT];
  logic [`DATA_W-1:0] modelMem [`DMEM_DEPTH]; // Kept across tests like the DUT memory
  logic [`DATA_W-1:0] expPc [$];
  logic [`DATA_W-1:0] expData [$];
  logic [2:0]         expReg [$];
  bit                 expWrite [$];
  instrWord           expInstr [$];
  logic               expErr;
  int                 errors, testErrors, testsRun;
  bit                 stopRun;             // Set by a timeout

  cpuCore cpuCore_i (
    .clk, .arstN, .imemAddr, .imemData,
    .retireValid, .retirePc, .retireWrite, .retireReg, .retireData,
    .halted, .err
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Combinational instruction memory, NOP past the end
  always_comb imemData = (imemAddr < progLen) ? prog[imemAddr] : instrWord'({`OP_NOP, 11'd0});

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return {16'd0, lcgState[30:15]};       // Upper bits mix better
  endfunction

  function automatic instrWord rInstr(input logic [2:0] rs, rt, rd, input logic [1:0] fn);
    instrWord w;
    w.rFmt = {`OP_RTYPE, rs, rt, rd, fn};
    return w;
  endfunction

  function automatic instrWord iInstr(input logic [4:0] op, input logic [2:0] rs, rd,
                                      input logic [4:0] imm);
    instrWord w;
    w.iFmt = {op, rs, rd, imm};
    return w;
  endfunction

  function automatic instrWord bInstr(input logic [4:0] op, input logic [2:0] rs,
                                      input logic [7:0] imm);
    instrWord w;
    w.bFmt = {op, rs, imm};
    return w;
  endfunction

  function automatic instrWord jInstr(input logic [4:0] op, input logic [10:0] imm);
    instrWord w;
    w.jFmt = {op, imm};
    return w;
  endfunction

  function automatic bit isLegal(input logic [4:0] op);
    case (op)
      `OP_HALT, `OP_NOP, `OP_RTYPE, `OP_ADDI, `OP_SUBI, `OP_LD, `OP_ST,
      `OP_LBI, `OP_BEQZ, `OP_BNEZ, `OP_J, `OP_JAL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic appendWord(input instrWord w);
    prog[progLen] = w;
    progLen++;
  endtask

  // Random ALU, LBI or NOP; half the time reads the previous dest
  task automatic appendAlu();
    logic [2:0] rs, rt, rd;
    int         kind;
    kind = nextRand() % 9;
    rs   = (nextRand() % 2) ? lastDest : 3'(nextRand());
    rt   = 3'(nextRand());
    rd   = 3'(nextRand());
    case (kind)
      0, 1:       appendWord(bInstr(`OP_LBI, rd, 8'(nextRand())));
      2, 3, 4, 5: appendWord(rInstr(rs, rt, rd, 2'(nextRand())));
      6:          appendWord(iInstr(`OP_ADDI, rs, rd, 5'(nextRand())));
      7:          appendWord(iInstr(`OP_SUBI, rs, rd, 5'(nextRand())));
      default:    appendWord(jInstr(`OP_NOP, '0));
    endcase
    lastDest = rd;
  endtask

  // Forward-only branch or jump, never past the HALT at haltAt
  task automatic appendBranch(input int haltAt);
    int         maxOff, off;
    logic [2:0] rs;
    maxOff = haltAt - progLen - 1;
    if (maxOff > 5) maxOff = 5;
    off = nextRand() % (maxOff + 1);
    rs  = (nextRand() % 2) ? lastDest : 3'(nextRand());
    case (nextRand() % 4)
      0:       appendWord(bInstr(`OP_BEQZ, rs, 8'(off)));
      1:       appendWord(bInstr(`OP_BNEZ, rs, 8'(off)));
      2:       appendWord(jInstr(`OP_J, 11'(off)));
      default: appendWord(jInstr(`OP_JAL, 11'(off)));
    endcase
  endtask

  task automatic buildMemProg();
    progLen = 0;
    for (int r = 1; r < `REG_CNT; r++)
      appendWord(bInstr(`OP_LBI, 3'(r), 8'(nextRand())));
    for (int a = 0; a < 16; a++)           // Fill words 0..15 before any load
      appendWord(iInstr(`OP_ST, 3'd0, 3'(1 + a % 7), 5'(a)));
    repeat (40) begin
      lastDest = 3'(1 + nextRand() % 7);   // r0 stays zero as the base
      case (nextRand() % 6)
        0, 1, 2: appendWord(iInstr(`OP_LD, 3'd0, lastDest, 5'(nextRand() % 16)));
        3, 4:    appendWord(iInstr(`OP_ST, 3'd0, lastDest, 5'(nextRand() % 16)));
        default: appendWord(iInstr(`OP_ADDI, 3'(1 + nextRand() % 7), lastDest, 5'(nextRand())));
      endcase
    end
    appendWord(jInstr(`OP_HALT, '0));
  endtask

  // ISA reference, one instruction at a time from pc 0
  task automatic runModel();
    instrWord           w;
    logic [`DATA_W-1:0] pc, nextPc, data, a, b, i5, i8, i11, addr;
    logic [2:0]         rd;
    bit                 wr, stop;
    int                 steps;
    expPc.delete();
    expData.delete();
    expReg.delete();
    expWrite.delete();
    expInstr.delete();
    expErr = 1'b0;
    foreach (modelRegs[r]) modelRegs[r] = '0;  // DUT regs clear on reset
    pc    = '0;
    stop  = 1'b0;
    steps = 0;
    while (!stop && steps < 1000) begin
      w      = prog[pc];
      a      = modelRegs[w.rFmt.rs];
      b      = modelRegs[w.rFmt.rt];
      i5     = {{(`DATA_W-5){w.iFmt.imm5[4]}}, w.iFmt.imm5};
      i8     = {{(`DATA_W-8){w.bFmt.imm8[7]}}, w.bFmt.imm8};
      i11    = {{(`DATA_W-11){w.jFmt.imm11[10]}}, w.jFmt.imm11};
      addr   = (a + i5) % `DMEM_DEPTH;
      nextPc = pc + 1'b1;
      wr     = 1'b0;
      rd     = w.iFmt.rd;                // I-format dest unless changed
      data   = '0;
      case (w.rFmt.op)
        `OP_HALT: stop = 1'b1;
        `OP_NOP: ;
        `OP_RTYPE: begin
          wr = 1'b1;
          rd = w.rFmt.rd;
          case (w.rFmt.funct)
            `FN_ADD: data = a + b;
            `FN_SUB: data = b - a;         // Second minus first
            `FN_XOR: data = a ^ b;
            default: data = a & ~b;
          endcase
        end
        `OP_ADDI: {wr, data} = {1'b1, a + i5};
        `OP_SUBI: {wr, data} = {1'b1, i5 - a};
        `OP_LD:   {wr, data} = {1'b1, modelMem[addr]};
        `OP_ST:   modelMem[addr] = modelRegs[w.iFmt.rd];
        `OP_LBI: begin
          {wr, data} = {1'b1, i8};
          rd = w.bFmt.rs;
        end
        `OP_BEQZ: if (a == '0) nextPc = pc + 1'b1 + i8;
        `OP_BNEZ: if (a != '0) nextPc = pc + 1'b1 + i8;
        `OP_J:    nextPc = pc + 1'b1 + i11;
        `OP_JAL: begin
          {wr, rd, data} = {1'b1, 3'd7, pc + 1'b1};  // Link into r7
          nextPc = pc + 1'b1 + i11;
        end
        default: {stop, expErr} = 2'b11;  // Illegal retires, then stops
      endcase
      expPc.push_back(pc);
      expWrite.push_back(wr);
      expReg.push_back(rd);
      expData.push_back(data);
      expInstr.push_back(w);
      if (wr) modelRegs[rd] = data;
      pc = nextPc;
      steps++;
    end
  endtask

  task automatic checkWord(input string name, input logic [`DATA_W-1:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkReg(input string name, input logic [2:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkInstr(input string name, input instrWord got, exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic reportTest(input string name);
    testsRun++;
    errors += testErrors;
    $display("Test %-10s %s, %0d errors", name, (testErrors == 0) ? "ok" : "FAIL", testErrors);
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1 arstN = 1'b0;
    repeat (4) @(posedge clk);
    #1 arstN = 1'b1;
  endtask

  // Runs prog, compares every retire in order, then watches for stragglers
  task automatic runProgram(input string name);
    int idx, cycles, limit;
    bit done;
    testErrors = 0;
    runModel();
    limit = 4 * progLen + 20;
    applyReset();
    {idx, cycles, done} = '0;
    while (!done && cycles < limit) begin
      @(negedge clk);                      // Outputs settled mid-cycle
      cycles++;
      if (retireValid && idx >= expPc.size()) begin
        $display("At %0t pc %h retired after the last expected instruction", $time, retirePc);
        testErrors++;
      end else if (retireValid) begin
        checkWord("retirePc", retirePc, expPc[idx]);
        checkInstr("retired instr", prog[retirePc], expInstr[idx]);
        checkFlag("retireWrite", retireWrite, expWrite[idx]);
        if (expWrite[idx]) begin
          checkReg("retireReg", retireReg, expReg[idx]);
          checkWord("retireData", retireData, expData[idx]);
        end
        idx++;
      end
      if (halted) begin
        if (idx < expPc.size()) begin
          $display("At %0t the core halted with %0d instructions not retired", $time,
                   expPc.size() - idx);
          testErrors++;
        end
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("Timeout in %s: no halt within %0d cycles", name, limit);
      testErrors++;
      stopRun = 1'b1;
    end else begin
      checkFlag("err", err, expErr);
      repeat (8) begin
        @(negedge clk);
        if (retireValid) begin
          $display("At %0t an instruction retired after the halt", $time);
          testErrors++;
        end
      end
      checkFlag("halted", halted, 1'b1);   // Sticky
    end
    reportTest(name);
  endtask

  initial begin
    arstN    = 1'b0;                       // Held low from time 0
    progLen  = 0;
    lastDest = '0;
    {errors, testsRun, stopRun} = '0;
    testErrors = 0;
    repeat (3) @(negedge clk);
    checkFlag("retireValid", retireValid, 1'b0);
    checkFlag("halted", halted, 1'b0);
    checkFlag("err", err, 1'b0);
    checkWord("imemAddr", imemAddr, '0);
    reportTest("reset");

    progLen = 0;
    repeat (40) appendAlu();
    appendWord(jInstr(`OP_HALT, '0));
    runProgram("alu");
    if (!stopRun) begin
      buildMemProg();
      runProgram("load/store");
    end
    if (!stopRun) begin
      progLen = 0;
      while (progLen < 40) begin
        if (nextRand() % 3 == 0) appendBranch(40);
        else appendAlu();
      end
      appendWord(jInstr(`OP_HALT, '0));
      runProgram("branch");
    end
    if (!stopRun) begin
      progLen = 0;
      repeat (6) appendAlu();
      appendWord(jInstr(`OP_HALT, '0));    // Younger words must not retire
      repeat (6) appendAlu();
      appendWord(jInstr(`OP_HALT, '0));
      runProgram("halt");
    end
    if (!stopRun) begin
      logic [4:0] op;
      progLen = 0;
      repeat (6) appendAlu();
      op = 5'(nextRand());
      while (isLegal(op))
        op = 5'(nextRand());
      appendWord(jInstr(op, 11'(nextRand())));
      repeat (6) appendAlu();
      appendWord(jInstr(`OP_HALT, '0));
      runProgram("illegal");
    end

    $display("Tests run: %0d, errors: %0d", testsRun, errors);
    if (errors == 0 && !stopRun)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+design
design/cpuPkg.sv
design/pipeBuses.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuCore.sv
testbench/tbCpu.sv
